//--- hdl/mipsPkg.sv
package mipsPkg;

  // ==========================================================
  // instruction encodings
  // ==========================================================

  // primary opcode in instr bits 31 to 26
  typedef enum logic [5:0] {
    opRtype = 6'd0,
    opJ     = 6'd2,
    opJal   = 6'd3,
    opBeq   = 6'd4,
    opLw    = 6'd35,
    opSw    = 6'd43
  } opcodeT;

  // funct field of r-type words in bits 5 to 0
  typedef enum logic [5:0] {
    fnAdd = 6'd32,
    fnSub = 6'd34,
    fnAnd = 6'd36,
    fnOr  = 6'd37,
    fnSlt = 6'd42
  } functT;

  // ==========================================================
  // internal alu control
  // ==========================================================

  // operation picked by decode and carried out in execute
  // aluNone makes the alu return zero
  typedef enum logic [3:0] {
    aluAnd,
    aluOr,
    aluAdd,
    aluSub,
    aluSlt,
    aluNone
  } aluOpT;

  // jal writes its return address here
  localparam logic [4:0] linkReg = 5'd31;

endpackage

//--- hdl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
  parameter logic [31:0] ResetVector = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        branchTaken,
  input  logic [31:0] branchOffset,
  input  logic        jump,
  input  logic [25:0] jumpField,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4
);

  logic [31:0] jumpTarget;
  logic [31:0] branchTarget;
  logic [31:0] nextPc;

  // sequential address
  assign pcPlus4 = pc + 32'd4;

  // pseudo-direct jump keeps the region of the delay-free successor
  assign jumpTarget = {pcPlus4[31:28], jumpField, 2'b00};

  // branch offset counts words relative to pc+4
  assign branchTarget = pcPlus4 + {branchOffset[29:0], 2'b00};

  // ==========================================================
  // next pc select
  // ==========================================================

  always_comb begin
    // jump wins over branch
    if (jump) begin
      nextPc = jumpTarget;
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // pc register
  // loads once per instruction
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= ResetVector;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic                clk,
  input  logic                rst,
  input  logic [31:0]         instr,
  output logic [4:0]          rsAddr,
  output logic [4:0]          rtAddr,
  output logic [4:0]          wrAddr,
  output logic [31:0]         imm,
  output logic [25:0]         jumpField,
  output mipsPkg::aluOpT      aluOp,
  output logic                aluSrcImm,
  output logic                memToReg,
  output logic                link,
  output logic                regWrite,
  output logic                memWrite,
  output logic                branch,
  output logic                jump
);

  import mipsPkg::*;

  opcodeT     opcode;
  functT      funct;
  logic [4:0] rdAddr;
  logic       regWriteRaw;
  logic       memWriteRaw;
  logic       runFlag;

  // ==========================================================
  // field extraction
  // ==========================================================

  assign opcode    = opcodeT'(instr[31:26]);
  assign funct     = functT'(instr[5:0]);
  assign rsAddr    = instr[25:21];
  assign rtAddr    = instr[20:16];
  assign rdAddr    = instr[15:11];
  assign jumpField = instr[25:0];

  // sign extend the 16 bit immediate
  assign imm = {{16{instr[15]}}, instr[15:0]};

  // ==========================================================
  // main control
  // ==========================================================

  always_comb begin
    // defaults describe a word that does nothing
    aluOp       = aluNone;
    aluSrcImm   = 1'b0;
    memToReg    = 1'b0;
    link        = 1'b0;
    regWriteRaw = 1'b0;
    memWriteRaw = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    wrAddr      = rdAddr;
    case (opcode)
      opRtype: begin
        // alu op from funct; unknown funct writes nothing
        regWriteRaw = 1'b1;
        case (funct)
          fnAdd:   aluOp = aluAdd;
          fnSub:   aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnSlt:   aluOp = aluSlt;
          default: regWriteRaw = 1'b0;
        endcase
      end
      opLw: begin
        aluOp       = aluAdd;
        aluSrcImm   = 1'b1;
        memToReg    = 1'b1;
        regWriteRaw = 1'b1;
        wrAddr      = rtAddr;
      end
      opSw: begin
        aluOp       = aluAdd;
        aluSrcImm   = 1'b1;
        memWriteRaw = 1'b1;
      end
      opBeq: begin
        // compare by subtraction
        aluOp  = aluSub;
        branch = 1'b1;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        jump        = 1'b1;
        link        = 1'b1;
        regWriteRaw = 1'b1;
        wrAddr      = linkReg;
      end
      default: begin
        // unsupported opcode just falls through to pc+4
        aluOp = aluNone;
      end
    endcase
  end

  // run flag
  // low from reset until the first edge after release
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      runFlag <= 1'b0;
    end else begin
      runFlag <= 1'b1;
    end
  end

  // no writes while stopped, and none to r0
  assign regWrite = regWriteRaw & runFlag & (wrAddr != 5'd0);
  assign memWrite = memWriteRaw & runFlag;

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  logic [4:0]  wrAddr,
  input  logic        regWrite,
  input  logic [31:0] wrData,
  output logic [31:0] rsData,
  output logic [31:0] rtData
);

  // general purpose registers
  logic [31:0] regs [32];

  // ==========================================================
  // write port
  // ==========================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // whole file cleared
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (regWrite && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ==========================================================
  // read ports
  // ==========================================================

  // asynchronous reads
  // r0 always reads as zero
  assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
  assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage #(
  parameter int DataAddrWidth = 7
) (
  input  logic [31:0]              rsData,
  input  logic [31:0]              rtData,
  input  logic [31:0]              imm,
  input  mipsPkg::aluOpT           aluOp,
  input  logic                     aluSrcImm,
  input  logic                     branch,
  output logic [31:0]              aluResult,
  output logic [DataAddrWidth-1:0] dataAddr,
  output logic                     branchTaken
);

  import mipsPkg::*;

  logic [31:0] operandB;
  logic        zero;

  // second operand is immediate for lw and sw
  assign operandB = aluSrcImm ? imm : rtData;

  // ==========================================================
  // alu
  // ==========================================================

  always_comb begin
    case (aluOp)
      aluAnd:  aluResult = rsData & operandB;
      aluOr:   aluResult = rsData | operandB;
      aluAdd:  aluResult = rsData + operandB;
      aluSub:  aluResult = rsData - operandB;
      // signed less-than
      aluSlt:  aluResult = {31'd0, $signed(rsData) < $signed(operandB)};
      default: aluResult = 32'd0;
    endcase
  end

  assign zero = (aluResult == 32'd0);

  // beq taken when the subtraction gives zero
  assign branchTaken = branch & zero;

  // word address drops the byte offset bits
  assign dataAddr = aluResult[DataAddrWidth+1:2];

endmodule

//--- hdl/singleCycleMips.sv
`timescale 1ns/1ps

module singleCycleMips #(
  parameter int          DataAddrWidth = 7,
  parameter logic [31:0] ResetVector   = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              instr,
  input  logic [31:0]              dataRead,
  output logic [31:0]              instrAddr,
  output logic [DataAddrWidth-1:0] dataAddr,
  output logic [31:0]              dataWrite,
  output logic                     memWriteN,
  output logic                     rfWriteEn,
  output logic [4:0]               rfWriteAddr,
  output logic [31:0]              rfWriteData
);

  import mipsPkg::*;

  // fetch outputs
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  // decode outputs
  logic [4:0]  rsAddr;
  logic [4:0]  rtAddr;
  logic [4:0]  wrAddr;
  logic [31:0] imm;
  logic [25:0] jumpField;
  aluOpT       aluOp;
  logic        aluSrcImm;
  logic        memToReg;
  logic        link;
  logic        regWrite;
  logic        memWrite;
  logic        branch;
  logic        jump;
  // register and alu data
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] aluResult;
  logic        branchTaken;
  logic [31:0] linkValue;
  logic [31:0] wbData;

  // ==========================================================
  // stages
  // ==========================================================

  fetchStage #(
    .ResetVector (ResetVector)
  ) fetchStage_i (
    .clk          (clk),
    .rst          (rst),
    .branchTaken  (branchTaken),
    .branchOffset (imm),
    .jump         (jump),
    .jumpField    (jumpField),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  decodeStage decodeStage_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .wrAddr    (wrAddr),
    .imm       (imm),
    .jumpField (jumpField),
    .aluOp     (aluOp),
    .aluSrcImm (aluSrcImm),
    .memToReg  (memToReg),
    .link      (link),
    .regWrite  (regWrite),
    .memWrite  (memWrite),
    .branch    (branch),
    .jump      (jump)
  );

  registerFile registerFile_i (
    .clk      (clk),
    .rst      (rst),
    .rsAddr   (rsAddr),
    .rtAddr   (rtAddr),
    .wrAddr   (wrAddr),
    .regWrite (regWrite),
    .wrData   (wbData),
    .rsData   (rsData),
    .rtData   (rtData)
  );

  executeStage #(
    .DataAddrWidth (DataAddrWidth)
  ) executeStage_i (
    .rsData      (rsData),
    .rtData      (rtData),
    .imm         (imm),
    .aluOp       (aluOp),
    .aluSrcImm   (aluSrcImm),
    .branch      (branch),
    .aluResult   (aluResult),
    .dataAddr    (dataAddr),
    .branchTaken (branchTaken)
  );

  // ==========================================================
  // writeback and memory side
  // ==========================================================

  // return address for jal
  assign linkValue = pcPlus4 + 32'd4;

  // link first, then load data, else alu
  assign wbData = link ? linkValue : (memToReg ? dataRead : aluResult);

  assign instrAddr = pc;
  // store data is the rt value
  assign dataWrite = rtData;
  // strobe is active low
  assign memWriteN = ~memWrite;

  // observation of the register write
  assign rfWriteEn   = regWrite;
  assign rfWriteAddr = wrAddr;
  assign rfWriteData = wbData;

endmodule

//--- verification/tbMemories.sv
`timescale 1ns/1ps

// program rom with one port for the DUT and one for the model
module instrRom (
  input  logic [31:0] addr,
  output logic [31:0] data,
  input  logic [31:0] modelAddr,
  output logic [31:0] modelData
);

  import mipsPkg::*;

  logic [31:0] rom [32];

  function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input functT funct);
    return {opRtype, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // target given as a word index
  function automatic logic [31:0] jType(input opcodeT op, input logic [25:0] target);
    return {op, target};
  endfunction

  // ==========================================================
  // test program
  // ==========================================================

  initial begin
    for (int i = 0; i < 32; i++) begin
      rom[i] = 32'd0;
    end
    // store at word 0 stays gated in reset and in the first cycle after
    rom[0]  = iType(opSw, 5'd0, 5'd0, 16'd0);
    rom[1]  = iType(opLw, 5'd0, 5'd1, 16'd0);
    rom[2]  = iType(opLw, 5'd0, 5'd2, 16'd4);
    rom[3]  = rType(5'd1, 5'd2, 5'd3, fnAdd);
    rom[4]  = rType(5'd1, 5'd2, 5'd4, fnSub);
    rom[5]  = rType(5'd1, 5'd2, 5'd5, fnAnd);
    rom[6]  = rType(5'd1, 5'd2, 5'd6, fnOr);
    rom[7]  = rType(5'd1, 5'd2, 5'd7, fnSlt);
    rom[8]  = rType(5'd2, 5'd1, 5'd8, fnSlt);
    // store then load back the same word
    rom[9]  = iType(opSw, 5'd0, 5'd3, 16'd8);
    rom[10] = iType(opLw, 5'd0, 5'd9, 16'd8);
    // r0 as target then r0 as source
    rom[11] = rType(5'd1, 5'd2, 5'd0, fnAdd);
    // r10 gets minus r1
    rom[12] = rType(5'd0, 5'd1, 5'd10, fnSub);
    // taken beq skips word 14
    rom[13] = iType(opBeq, 5'd9, 5'd3, 16'd1);
    rom[14] = rType(5'd1, 5'd1, 5'd11, fnAdd);
    // not taken for distinct random operands
    rom[15] = iType(opBeq, 5'd1, 5'd2, 16'd4);
    rom[16] = jType(opJ, 26'd18);
    rom[17] = rType(5'd1, 5'd1, 5'd11, fnAdd);
    rom[18] = jType(opJal, 26'd21);
    rom[19] = rType(5'd1, 5'd1, 5'd11, fnAdd);
    rom[20] = rType(5'd1, 5'd1, 5'd11, fnAdd);
    // link value goes through memory
    rom[21] = iType(opSw, 5'd0, 5'd31, 16'd12);
    rom[22] = iType(opLw, 5'd0, 5'd13, 16'd12);
    // base register with a random value
    rom[23] = iType(opSw, 5'd6, 5'd2, 16'd16);
    rom[24] = iType(opLw, 5'd6, 5'd14, 16'd16);
    // operands of opposite sign for signed slt
    rom[25] = rType(5'd10, 5'd1, 5'd15, fnSlt);
    // opcode 8 is not supported
    rom[26] = {6'd8, 5'd1, 5'd16, 16'h0005};
    // closing self-jump
    rom[27] = jType(opJ, 26'd27);
  end

  assign data      = rom[addr[6:2]];
  assign modelData = rom[modelAddr[6:2]];

endmodule

// data ram with combinational read and clocked write
module dataRam #(
  parameter int AddrWidth = 7
) (
  input  logic                 clk,
  input  logic [AddrWidth-1:0] addr,
  input  logic [31:0]          writeData,
  input  logic                 writeN,
  output logic [31:0]          readData,
  input  logic                 loadNow,
  input  logic [31:0]          image [2**AddrWidth]
);

  logic [31:0] mem [2**AddrWidth];

  // whole image copied in one edge
  always_ff @(posedge clk) begin
    if (loadNow) begin
      for (int i = 0; i < 2**AddrWidth; i++) begin
        mem[i] <= image[i];
      end
    end else if (!writeN) begin
      mem[addr] <= writeData;
    end
  end

  assign readData = mem[addr];

endmodule

//--- verification/mipsTb.sv
`timescale 1ns/1ps

module mipsTb;

  import mipsPkg::*;

  localparam int          DataAddrWidth = 7;
  localparam int          RamWords      = 2 ** DataAddrWidth;
  localparam logic [31:0] ResetVector   = 32'h0000_0000;
  // byte address of the closing self-jump
  localparam logic [31:0] HaltAddr      = 32'd108;
  localparam int          MaxCycles     = 200;

  logic                     clk;
  logic                     rst;
  logic [31:0]              instr;
  logic [31:0]              dataRead;
  logic [31:0]              instrAddr;
  logic [DataAddrWidth-1:0] dataAddr;
  logic [31:0]              dataWrite;
  logic                     memWriteN;
  logic                     rfWriteEn;
  logic [4:0]               rfWriteAddr;
  logic [31:0]              rfWriteData;

  // ram image and its loader
  logic        loadNow;
  logic [31:0] ramImage [RamWords];
  logic [31:0] seed;

  // instruction-level model state
  logic [31:0] modelPc;
  logic [31:0] modelInstr;
  logic        modelRun;
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [RamWords];

  int   errors;
  int   checks;
  int   cycles;
  logic timedOut;

  singleCycleMips #(
    .DataAddrWidth (DataAddrWidth),
    .ResetVector   (ResetVector)
  ) singleCycleMips_i (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .dataRead    (dataRead),
    .instrAddr   (instrAddr),
    .dataAddr    (dataAddr),
    .dataWrite   (dataWrite),
    .memWriteN   (memWriteN),
    .rfWriteEn   (rfWriteEn),
    .rfWriteAddr (rfWriteAddr),
    .rfWriteData (rfWriteData)
  );

  instrRom instrRom_i (
    .addr      (instrAddr),
    .data      (instr),
    .modelAddr (modelPc),
    .modelData (modelInstr)
  );

  dataRam #(
    .AddrWidth (DataAddrWidth)
  ) dataRam_i (
    .clk       (clk),
    .addr      (dataAddr),
    .writeData (dataWrite),
    .writeN    (memWriteN),
    .readData  (dataRead),
    .loadNow   (loadNow),
    .image     (ramImage)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // xorshift32 with shifts 13, 17, 5
  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // mnemonic used as the check name
  function automatic string kindName(input logic [31:0] word);
    string name;
    name = "other";
    case (opcodeT'(word[31:26]))
      opRtype: begin
        case (functT'(word[5:0]))
          fnAdd:   name = "add";
          fnSub:   name = "sub";
          fnAnd:   name = "and";
          fnOr:    name = "or";
          fnSlt:   name = "slt";
          default: name = "rtype other";
        endcase
      end
      opLw:    name = "lw";
      opSw:    name = "sw";
      opBeq:   name = "beq";
      opJ:     name = "j";
      opJal:   name = "jal";
      default: name = "other";
    endcase
    return name;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // ==========================================================
  // reference model, one instruction per rising edge
  // ==========================================================

  // DUT outputs still hold the values of the ending cycle here
  always @(posedge clk) begin : modelStep
    logic [31:0]              word;
    logic [31:0]              a;
    logic [31:0]              b;
    logic [31:0]              imm;
    logic [31:0]              pcPlus4;
    logic [31:0]              nextPc;
    logic [31:0]              addrSum;
    logic [31:0]              expData;
    logic [4:0]               expAddr;
    logic                     expWe;
    logic                     expStore;
    logic [DataAddrWidth-1:0] wordAddr;
    string                    kind;
    if (!rst) begin
      checkValue("reset instrAddr", ResetVector, instrAddr);
      checkValue("reset memWriteN", 32'd1, 32'(memWriteN));
      checkValue("reset rfWriteEn", 32'd0, 32'(rfWriteEn));
      modelPc  <= ResetVector;
      modelRun <= 1'b0;
      for (int i = 0; i < 32; i++) begin
        modelRegs[i] <= 32'd0;
      end
      // same image as the ram
      if (loadNow) begin
        for (int i = 0; i < RamWords; i++) begin
          modelMem[i] <= ramImage[i];
        end
      end
    end else begin
      word     = modelInstr;
      kind     = kindName(word);
      a        = modelRegs[word[25:21]];
      b        = modelRegs[word[20:16]];
      imm      = {{16{word[15]}}, word[15:0]};
      pcPlus4  = modelPc + 32'd4;
      nextPc   = pcPlus4;
      addrSum  = a + imm;
      wordAddr = addrSum[DataAddrWidth+1:2];
      expWe    = 1'b0;
      expStore = 1'b0;
      expAddr  = word[15:11];
      expData  = 32'd0;
      case (opcodeT'(word[31:26]))
        opRtype: begin
          expWe = 1'b1;
          case (functT'(word[5:0]))
            fnAdd:   expData = a + b;
            fnSub:   expData = a - b;
            fnAnd:   expData = a & b;
            fnOr:    expData = a | b;
            fnSlt:   expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: expWe = 1'b0;
          endcase
        end
        opLw: begin
          expWe   = 1'b1;
          expAddr = word[20:16];
          expData = modelMem[wordAddr];
        end
        opSw: begin
          expStore = 1'b1;
        end
        opBeq: begin
          // word offset from pc+4
          if (a == b) begin
            nextPc = pcPlus4 + {imm[29:0], 2'b00};
          end
        end
        opJ: begin
          nextPc = {pcPlus4[31:28], word[25:0], 2'b00};
        end
        opJal: begin
          nextPc  = {pcPlus4[31:28], word[25:0], 2'b00};
          expWe   = 1'b1;
          expAddr = linkReg;
          expData = modelPc + 32'd8;
        end
        default: begin
          // unsupported opcode only advances the pc
          expWe = 1'b0;
        end
      endcase
      // no write to r0 and none in the first cycle after reset
      if (expAddr == 5'd0 || !modelRun) begin
        expWe = 1'b0;
      end
      if (!modelRun) begin
        expStore = 1'b0;
      end
      checkValue({kind, " instrAddr"}, modelPc, instrAddr);
      checkValue({kind, " rfWriteEn"}, 32'(expWe), 32'(rfWriteEn));
      checkValue({kind, " memWriteN"}, 32'(!expStore), 32'(memWriteN));
      if (expWe) begin
        checkValue({kind, " rfWriteAddr"}, 32'(expAddr), 32'(rfWriteAddr));
        checkValue({kind, " rfWriteData"}, expData, rfWriteData);
        modelRegs[expAddr] <= expData;
      end
      if (expStore) begin
        checkValue({kind, " dataAddr"}, 32'(wordAddr), 32'(dataAddr));
        checkValue({kind, " dataWrite"}, b, dataWrite);
        modelMem[wordAddr] <= b;
      end
      modelPc  <= nextPc;
      modelRun <= 1'b1;
    end
  end

  // ==========================================================
  // stimulus and end of run
  // ==========================================================

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    loadNow  = 1'b0;
    errors   = 0;
    checks   = 0;
    cycles   = 0;
    timedOut = 1'b0;
    seed     = 32'ha7c6adf0;
    for (int i = 0; i < RamWords; i++) begin
      seed        = nextRandom(seed);
      ramImage[i] = seed;
    end
    // definite falling edge on rst
    #1;
    rst = 1'b0;
    @(negedge clk);
    loadNow = 1'b1;
    @(negedge clk);
    loadNow = 1'b0;
    repeat (2) @(negedge clk);
    // four rising edges seen in reset
    rst = 1'b1;
    while (instrAddr !== HaltAddr && cycles < MaxCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (instrAddr !== HaltAddr) begin
      timedOut = 1'b1;
      $display("timeout: the program did not reach its final jump in %0d cycles", MaxCycles);
    end else begin
      // self-jump retires twice
      repeat (2) @(negedge clk);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timedOut) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/registerFile.sv
hdl/executeStage.sv
hdl/singleCycleMips.sv
verification/tbMemories.sv
verification/mipsTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mipsTb
FILELIST  ?= verilog.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
FAILMSG   := Simulation finished: FAIL
PASSMSG   := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o $(TOP)
	./$(BUILDDIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "result: failed"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "result: no result line in $(LOG)"; exit 1; fi
	@echo "result: passed"

clean:
	rm -rf $(BUILDDIR) $(LOG)
